//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
LINT      := --lint-only --timing -Wall
TOP       := tb_mesh_tile
FLIST     := flist.f
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	-./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

//--- flist.f
+incdir+.
tile_pkg.sv
next_hop_route.sv
link_fifo.sv
out_port_arb.sv
tile_router.sv
local_mem_core.sv
mesh_tile.sv
mesh_tile_props.sv
tb_mesh_tile.sv

//--- link_fifo.sv
// per link transaction FIFO
`timescale 1ns/1ns
`include "tile_consts.svh"

module link_fifo
import tile_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_en,
    input  t_tile_trans wr_data,
    input  logic        rd_en,
    output t_tile_trans rd_data,
    output logic        not_empty,
    output logic        not_full
);

    localparam int DEPTH = `TILE_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    t_tile_trans      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;   // one extra bit for the full state
    logic             push;
    logic             pop;

    assign not_empty = (count != '0);
    assign not_full  = (count != (PTR_W+1)'(DEPTH));
    assign push      = wr_en && not_full; // writes into a full fifo are refused
    assign pop       = rd_en && not_empty;
    assign rd_data   = mem[rd_ptr];       // head, no read latency

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1; // wraps at power of two
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= wr_data;
    end

endmodule

//--- local_mem_core.sv
// local memory endpoint
`timescale 1ns/1ns
`include "tile_consts.svh"

module local_mem_core
import tile_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  t_tile_id    local_tile_id,
    // from the router local output
    input  logic        core_in_valid,
    input  t_tile_trans core_in,
    output logic        core_ready,
    // read responses toward the router
    output logic        core_req_valid,
    output t_tile_trans core_req,
    input  logic        core_req_ready
);

    localparam int AW = $clog2(`TILE_MEM_WORDS);

    logic [31:0]   mem [`TILE_MEM_WORDS];
    logic [AW-1:0] word_idx;
    logic          accept;
    logic          is_wr;
    logic          is_rd;
    t_tile_trans   rsp_next;

    assign core_ready = !core_req_valid; // one response buffer
    assign accept     = core_in_valid && core_ready;
    assign word_idx   = core_in.address[AW+1:2];   // word aligned
    assign is_wr      = accept && (core_in.opcode == WR);
    assign is_rd      = accept && (core_in.opcode == RD);
    // a stray RD_RSP is accepted and dropped

    // response: return tile on top, then the responder, then the tag
    always_comb begin : build_rsp
        rsp_next = '0; // tag left zero, set by the tile route stage
        rsp_next.address = {core_in.payload.rd_req.return_id, local_tile_id, 8'h00,
                            core_in.payload.rd_req.tag};
        rsp_next.opcode      = RD_RSP;
        rsp_next.payload.raw = mem[word_idx];
    end

    // ==========================================================
    // storage and response buffer
    // ==========================================================
    always_ff @(posedge clk) begin
        if (is_wr) mem[word_idx] <= core_in.payload.raw; // done in the accept cycle
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            core_req_valid <= 1'b0;
        end else if (is_rd) begin
            core_req_valid <= 1'b1;          // next cycle after accept
        end else if (core_req_valid && core_req_ready) begin
            core_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (is_rd) core_req <= rsp_next;
    end

endmodule

//--- mesh_tile.sv
// mesh tile top
`timescale 1ns/1ns

module mesh_tile
import tile_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  t_tile_id    local_tile_id,
    // north
    input  logic        in_north_req_valid,
    input  t_tile_trans in_north_req,
    output t_fab_ready  out_north_ready,
    output logic        out_north_req_valid,
    output t_tile_trans out_north_req,
    input  t_fab_ready  in_north_ready,
    // east
    input  logic        in_east_req_valid,
    input  t_tile_trans in_east_req,
    output t_fab_ready  out_east_ready,
    output logic        out_east_req_valid,
    output t_tile_trans out_east_req,
    input  t_fab_ready  in_east_ready,
    // south
    input  logic        in_south_req_valid,
    input  t_tile_trans in_south_req,
    output t_fab_ready  out_south_ready,
    output logic        out_south_req_valid,
    output t_tile_trans out_south_req,
    input  t_fab_ready  in_south_ready,
    // west
    input  logic        in_west_req_valid,
    input  t_tile_trans in_west_req,
    output t_fab_ready  out_west_ready,
    output logic        out_west_req_valid,
    output t_tile_trans out_west_req,
    input  t_fab_ready  in_west_ready
);

    logic        core_req_valid;
    t_tile_trans core_req;        // untagged
    logic        core_req_ready;
    t_tile_trans in_local_req;    // tagged for this tile
    t_fab_ready  in_local_ready;  // router local input space
    logic        out_local_req_valid;
    t_tile_trans out_local_req;
    logic        core_ready;
    t_cardinal   local_dir;

    // ==========================================================
    // local next hop, this tile is the receiving hop
    // ==========================================================
    next_hop_route u_local_route (
        .dest_id (core_req.address[31:24]),
        .hop_id  (local_tile_id),
        .hop_dir (local_dir)
    );

    always_comb begin
        in_local_req = core_req;
        in_local_req.next_tile_fifo_arb_id = local_dir;
    end

    assign core_req_ready = in_local_ready[local_dir]; // space in the chosen fifo

    // ==========================================================
    // router
    // ==========================================================
    tile_router u_router (
        .clk                 (clk),
        .rst_n               (rst_n),
        .local_tile_id       (local_tile_id),
        .in_north_req_valid  (in_north_req_valid),
        .in_north_req        (in_north_req),
        .out_north_ready     (out_north_ready),
        .out_north_req_valid (out_north_req_valid),
        .out_north_req       (out_north_req),
        .in_north_ready      (in_north_ready),
        .in_east_req_valid   (in_east_req_valid),
        .in_east_req         (in_east_req),
        .out_east_ready      (out_east_ready),
        .out_east_req_valid  (out_east_req_valid),
        .out_east_req        (out_east_req),
        .in_east_ready       (in_east_ready),
        .in_south_req_valid  (in_south_req_valid),
        .in_south_req        (in_south_req),
        .out_south_ready     (out_south_ready),
        .out_south_req_valid (out_south_req_valid),
        .out_south_req       (out_south_req),
        .in_south_ready      (in_south_ready),
        .in_west_req_valid   (in_west_req_valid),
        .in_west_req         (in_west_req),
        .out_west_ready      (out_west_ready),
        .out_west_req_valid  (out_west_req_valid),
        .out_west_req        (out_west_req),
        .in_west_ready       (in_west_ready),
        .in_local_req_valid  (core_req_valid),
        .in_local_req        (in_local_req),
        .out_local_ready     (in_local_ready),
        .out_local_req_valid (out_local_req_valid),
        .out_local_req       (out_local_req),
        .in_local_ready      ({5{core_ready}}) // core takes from any fifo
    );

    // ==========================================================
    // memory endpoint
    // ==========================================================
    local_mem_core u_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .local_tile_id  (local_tile_id),
        .core_in_valid  (out_local_req_valid),
        .core_in        (out_local_req),
        .core_ready     (core_ready),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready)
    );

endmodule

//--- mesh_tile_props.sv
// mesh tile assertions
`timescale 1ns/1ns

module mesh_tile_props
import tile_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input t_tile_id    local_tile_id,
    input logic        core_req_valid,
    input logic        out_north_req_valid,
    input t_tile_trans out_north_req,
    input logic        out_east_req_valid,
    input t_tile_trans out_east_req,
    input t_fab_ready  in_east_ready,
    input logic        out_south_req_valid,
    input t_tile_trans out_south_req,
    input logic        out_west_req_valid,
    input t_tile_trans out_west_req,
    input logic        in_west_req_valid,
    input t_tile_trans in_west_req,
    input t_fab_ready  out_west_ready,
    input logic [4:0]  east_heads       // fifo heads waiting for the east output
);

    // x first then y growing southward
    function automatic t_cardinal xy(input t_tile_id dest, input t_tile_id hop);
        if (dest[3:0] != hop[3:0]) return (dest[3:0] > hop[3:0]) ? EAST : WEST;
        if (dest[7:4] != hop[7:4]) return (dest[7:4] > hop[7:4]) ? SOUTH : NORTH;
        return LOCAL;
    endfunction

    // ==========================================================
    // reset and hold
    // ==========================================================
    a_reset_idle: assert property (@(posedge clk) !rst_n |=> !out_north_req_valid
        && !out_east_req_valid && !out_south_req_valid && !out_west_req_valid
        && !core_req_valid) else $error("valid raised out of reset");

    a_hold_e: assert property (@(posedge clk) disable iff (!rst_n)
        out_east_req_valid && !in_east_ready[out_east_req.next_tile_fifo_arb_id]
        |=> out_east_req_valid && $stable(out_east_req)) else $error("east not held");

    // two cycles west to east when idle
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        in_west_req_valid && out_west_ready[EAST] && in_west_req.next_tile_fifo_arb_id == EAST
        && !out_east_req_valid && east_heads == 5'b0 |-> ##2 out_east_req_valid)
        else $error("west to east latency is not 2 cycles");

    // ==========================================================
    // neighbor tag
    // ==========================================================
    a_tag_n: assert property (@(posedge clk) disable iff (!rst_n) out_north_req_valid
        |-> out_north_req.next_tile_fifo_arb_id == xy(out_north_req.address[31:24],
            {local_tile_id[7:4] - 4'd1, local_tile_id[3:0]})) else $error("north tag");
    a_tag_e: assert property (@(posedge clk) disable iff (!rst_n) out_east_req_valid
        |-> out_east_req.next_tile_fifo_arb_id == xy(out_east_req.address[31:24],
            {local_tile_id[7:4], local_tile_id[3:0] + 4'd1})) else $error("east tag");
    a_tag_s: assert property (@(posedge clk) disable iff (!rst_n) out_south_req_valid
        |-> out_south_req.next_tile_fifo_arb_id == xy(out_south_req.address[31:24],
            {local_tile_id[7:4] + 4'd1, local_tile_id[3:0]})) else $error("south tag");
    a_tag_w: assert property (@(posedge clk) disable iff (!rst_n) out_west_req_valid
        |-> out_west_req.next_tile_fifo_arb_id == xy(out_west_req.address[31:24],
            {local_tile_id[7:4], local_tile_id[3:0] - 4'd1})) else $error("west tag");

endmodule

bind mesh_tile mesh_tile_props u_props (.*, .east_heads(u_router.head_vld[1]));

//--- next_hop_route.sv
// xy next hop direction
`timescale 1ns/1ns
`include "tile_consts.svh"

module next_hop_route
import tile_pkg::*;
(
    input  t_tile_id  dest_id,
    input  t_tile_id  hop_id,  // tile that will receive the transaction
    output t_cardinal hop_dir  // fifo that tile must use
);

    localparam int XW = `TILE_ID_W / 2;

    logic [XW-1:0] dest_x;
    logic [XW-1:0] dest_y;
    logic [XW-1:0] hop_x;
    logic [XW-1:0] hop_y;

    assign dest_x = dest_id[XW-1:0];
    assign dest_y = dest_id[`TILE_ID_W-1:XW];
    assign hop_x  = hop_id[XW-1:0];
    assign hop_y  = hop_id[`TILE_ID_W-1:XW];

    // x first, then y; y grows toward the south
    always_comb begin : xy_pick
        if (dest_x > hop_x) begin
            hop_dir = EAST;
        end else if (dest_x < hop_x) begin
            hop_dir = WEST;
        end else if (dest_y > hop_y) begin
            hop_dir = SOUTH;
        end else if (dest_y < hop_y) begin
            hop_dir = NORTH;
        end else begin
            hop_dir = LOCAL; // arrived
        end
    end

endmodule

//--- out_port_arb.sv
// round-robin output arbiter
`timescale 1ns/1ns
`include "tile_consts.svh"

module out_port_arb
import tile_pkg::*;
#(
    parameter t_cardinal OUT_DIR = LOCAL
)(
    input  logic        clk,
    input  logic        rst_n,
    input  t_tile_id    local_tile_id,
    input  logic [4:0]  src_valid,      // fifo heads aimed at this output
    input  t_tile_trans src_trans [5],
    output logic [4:0]  src_pop,
    output logic        out_valid,
    output t_tile_trans out_trans,
    input  t_fab_ready  out_ready       // neighbor fifo space
);

    localparam int XW = `TILE_ID_W / 2;

    logic [2:0]  rr_ptr;   // first source to look at
    logic [2:0]  gnt_idx;
    logic        gnt_vld;
    logic        xfer;
    logic        load;
    t_tile_id    nbr_id;
    t_cardinal   nbr_dir;
    t_tile_trans gnt_trans;
    t_tile_trans load_trans;

    // ==========================================================
    // grant
    // ==========================================================
    assign xfer = out_valid && out_ready[out_trans.next_tile_fifo_arb_id];
    assign load = gnt_vld && (!out_valid || xfer); // empty or draining this cycle

    always_comb begin : rr_pick
        int unsigned slot;
        gnt_vld = 1'b0;
        gnt_idx = '0;
        for (int i = 0; i < 5; i++) begin
            slot = (int'(rr_ptr) + i) % 5;
            if (!gnt_vld && src_valid[slot]) begin
                gnt_vld = 1'b1;
                gnt_idx = 3'(slot);
            end
        end
    end

    always_comb begin
        src_pop = '0;
        if (load) src_pop[gnt_idx] = 1'b1;
    end

    assign gnt_trans = src_trans[gnt_idx];

    // ==========================================================
    // next hop tag
    // ==========================================================
    always_comb begin : nbr_calc
        nbr_id = local_tile_id;
        case (OUT_DIR)
            EAST:    nbr_id[XW-1:0] = local_tile_id[XW-1:0] + XW'(1);
            WEST:    nbr_id[XW-1:0] = local_tile_id[XW-1:0] - XW'(1);
            NORTH:   nbr_id[`TILE_ID_W-1:XW] = local_tile_id[`TILE_ID_W-1:XW] - XW'(1);
            SOUTH:   nbr_id[`TILE_ID_W-1:XW] = local_tile_id[`TILE_ID_W-1:XW] + XW'(1);
            default: ; // local, same tile
        endcase
    end

    next_hop_route u_route (
        .dest_id (gnt_trans.address[`TILE_ADDR_W-1 -: `TILE_ID_W]),
        .hop_id  (nbr_id),
        .hop_dir (nbr_dir)
    );

    always_comb begin
        load_trans = gnt_trans;
        load_trans.next_tile_fifo_arb_id = (OUT_DIR == LOCAL) ? LOCAL : nbr_dir;
    end

    // ==========================================================
    // output register
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            rr_ptr    <= '0;
        end else if (load) begin
            out_valid <= 1'b1;
            rr_ptr    <= (gnt_idx == 3'd4) ? 3'd0 : gnt_idx + 3'd1; // past the winner
        end else if (xfer) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) out_trans <= load_trans; // held until transfer
    end

endmodule

//--- tb_mesh_tile.sv
// mesh tile testbench
`timescale 1ns/1ns

module tb_mesh_tile
import tile_pkg::*;
();

    localparam t_tile_id MY_ID = 8'h11;

    logic        clk;
    logic        rst_n;
    logic        in_valid [4];  // neighbor senders by side
    t_tile_trans in_req   [4];
    t_fab_ready  up_ready [4];  // dut fifo space per input
    logic        dn_valid [4];  // dut outputs
    t_tile_trans dn_req   [4];
    t_fab_ready  dn_ready [4];  // neighbor fifo space

    t_tile_trans exp_q [4][$];  // expected per output
    int          src_q [4][$];  // source side of each entry
    int          pend  [5];
    int          gap   [5];
    bit          fair_on;
    string       test_name;
    int          seed = 7718;

    mesh_tile uut (
        .clk(clk), .rst_n(rst_n), .local_tile_id(MY_ID),
        .in_north_req_valid(in_valid[0]), .in_north_req(in_req[0]),
        .out_north_ready(up_ready[0]), .out_north_req_valid(dn_valid[0]),
        .out_north_req(dn_req[0]), .in_north_ready(dn_ready[0]),
        .in_east_req_valid(in_valid[1]), .in_east_req(in_req[1]),
        .out_east_ready(up_ready[1]), .out_east_req_valid(dn_valid[1]),
        .out_east_req(dn_req[1]), .in_east_ready(dn_ready[1]),
        .in_south_req_valid(in_valid[2]), .in_south_req(in_req[2]),
        .out_south_ready(up_ready[2]), .out_south_req_valid(dn_valid[2]),
        .out_south_req(dn_req[2]), .in_south_ready(dn_ready[2]),
        .in_west_req_valid(in_valid[3]), .in_west_req(in_req[3]),
        .out_west_ready(up_ready[3]), .out_west_req_valid(dn_valid[3]),
        .out_west_req(dn_req[3]), .in_west_ready(dn_ready[3])
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x until it matches then y
    function automatic t_cardinal route_dir(input t_tile_id dest, input t_tile_id hop);
        if (dest[3:0] > hop[3:0]) return EAST;
        if (dest[3:0] < hop[3:0]) return WEST;
        if (dest[7:4] > hop[7:4]) return SOUTH;
        if (dest[7:4] < hop[7:4]) return NORTH;
        return LOCAL;
    endfunction

    function automatic t_tile_id nbr_of(input int side);
        case (side)
            0:       return MY_ID - 8'h10;
            1:       return MY_ID + 8'h01;
            2:       return MY_ID + 8'h10;
            default: return MY_ID - 8'h01;
        endcase
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // ==========================================================
    // scoreboard
    // ==========================================================
    task automatic check_arrival(input int o, input t_tile_trans t);
        int k;
        int s;
        k = -1;
        for (int j = 0; j < exp_q[o].size(); j++) begin
            if (k < 0 && exp_q[o][j] == t) k = j;
        end
        assert (k >= 0) else stop_on_error($sformatf("FAIL %s expected %h actual %h",
            test_name, (exp_q[o].size() > 0) ? exp_q[o][0] : '0, t));
        s = src_q[o][k];
        for (int j = 0; j < k; j++) begin
            assert (src_q[o][j] != s) else stop_on_error($sformatf(
                "FAIL %s expected %h actual %h", test_name, exp_q[o][j], t));
        end
        exp_q[o].delete(k);
        src_q[o].delete(k);
        pend[s]--;
        if (fair_on) begin
            for (int p = 0; p < 5; p++) begin
                if (p != s && pend[p] > 0) gap[p]++;
                assert (gap[p] <= 3) else stop_on_error($sformatf(
                    "source %0d waited more than three grants in %s", p, test_name));
            end
            gap[s] = 0;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            for (int o = 0; o < 4; o++) begin
                if (dn_valid[o] && dn_ready[o][dn_req[o].next_tile_fifo_arb_id])
                    check_arrival(o, dn_req[o]);
            end
        end
    end

    // ==========================================================
    // drivers
    // ==========================================================
    task automatic send(input int side, input t_tile_trans t);
        int waited;
        waited = 0;
        while (!up_ready[side][t.next_tile_fifo_arb_id]) begin
            waited++;
            assert (waited < 200) else stop_on_error("input never became ready");
            @(negedge clk);
        end
        in_valid[side] = 1'b1;
        in_req[side]   = t;
        @(negedge clk);
        in_valid[side] = 1'b0;
    endtask

    // tag for this tile then queue the expected exit and drive
    task automatic send_routed(input int side, input t_tile_trans t, input int src);
        t_cardinal  o;
        t_tile_trans e;
        o = route_dir(t.address[31:24], MY_ID);
        t.next_tile_fifo_arb_id = o;
        if (o != LOCAL) begin
            e = t;
            e.next_tile_fifo_arb_id = route_dir(t.address[31:24], nbr_of(int'(o)));
            exp_q[o].push_back(e);
            src_q[o].push_back(src);
            pend[src]++;
        end
        send(side, t);
    endtask

    task automatic make_wr(input t_tile_id dest, output t_tile_trans t);
        t = '0;
        t.address     = {dest, 24'($random(seed))};
        t.opcode      = WR;
        t.payload.raw = $random(seed);
    endtask

    task automatic stream(input int side, input int n, input t_tile_id dest, input bit gaps);
        t_tile_trans t;
        for (int i = 0; i < n; i++) begin
            make_wr(dest, t);
            send_routed(side, t, side);
            if (gaps) repeat ($unsigned($random(seed)) % 3) @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() > 0) begin
            waited++;
            assert (waited < 1000) else stop_on_error("expected transactions never arrived");
            @(negedge clk);
        end
    endtask

    initial begin
        t_tile_trans t;
        t_tile_id    d;
        int          s;
        rst_n   = 1'b0;
        fair_on = 1'b0;
        for (int i = 0; i < 4; i++) begin
            in_valid[i] = 1'b0;
            in_req[i]   = '0;
            dn_ready[i] = 5'h1f;
        end
        for (int i = 0; i < 5; i++) begin
            pend[i] = 0;
            gap[i]  = 0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_name = "reset";
        for (int i = 0; i < 4; i++) begin
            assert (!dn_valid[i]) else stop_on_error($sformatf(
                "FAIL %s expected 0 actual %b", test_name, dn_valid[i]));
            assert (up_ready[i] == (5'h1f & ~(5'b1 << i))) else stop_on_error($sformatf(
                "FAIL %s expected %h actual %h", test_name, 5'h1f & ~(5'b1 << i), up_ready[i]));
        end
        assert (uut.core_ready) else stop_on_error($sformatf(
            "FAIL %s expected 1 actual %b", test_name, uut.core_ready));

        test_name = "pass_through";
        for (int n = 0; n < 24; n++) begin
            d = 8'($random(seed));
            if (n < 4) d = nbr_of(n); // one per side first
            if (d == MY_ID) d = 8'h15;
            s = $unsigned($random(seed)) % 4;
            if (s == int'(route_dir(d, MY_ID))) s = (s + 1) % 4; // no u-turn
            make_wr(d, t);
            send_routed(s, t, s);
        end
        wait_drain();

        test_name = "local_memory";
        for (int w = 0; w < 4; w++) begin
            t = '0;
            t.address = {MY_ID, 18'h0, 4'(w), 2'b00};
            t.payload.raw = 32'hc0de_0000 + w * 32'h111;
            send_routed(3, t, 3);
        end
        for (int w = 0; w < 4; w++) begin
            d = (w % 2) ? 8'h01 : 8'h13; // responses leave north or east
            t = '0;
            t.address = {MY_ID, 18'h0, 4'(w), 2'b00};
            t.opcode = RD;
            t.payload.rd_req.return_id = d;
            t.payload.rd_req.tag = 8'(8'ha0 + w);
            send_routed(3, t, 3);
            t = '0;
            t.address = {d, MY_ID, 8'h00, 8'(8'ha0 + w)};
            t.opcode = RD_RSP;
            t.payload.raw = 32'hc0de_0000 + w * 32'h111;
            t.next_tile_fifo_arb_id = route_dir(d, nbr_of(int'(route_dir(d, MY_ID))));
            exp_q[route_dir(d, MY_ID)].push_back(t);
            src_q[route_dir(d, MY_ID)].push_back(4);
            pend[4]++;
        end
        wait_drain();

        test_name = "back_pressure";
        dn_ready[1] = 5'h00;
        fork
            stream(3, 4, 8'h14, 1'b1);
            stream(0, 4, 8'h36, 1'b1);
            begin
                repeat (30) @(negedge clk);
                dn_ready[1] = 5'h1f;
            end
        join
        wait_drain();

        test_name = "contention";
        fair_on = 1'b1;
        fork
            stream(3, 8, 8'h17, 1'b0);
            stream(0, 8, 8'h28, 1'b0);
            stream(2, 8, 8'h05, 1'b0);
        join
        wait_drain();
        fair_on = 1'b0;

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- tile_consts.svh
// tile fabric constants
`ifndef TILE_CONSTS_SVH
`define TILE_CONSTS_SVH

// link buffering, power of two
`define TILE_FIFO_DEPTH 2

// local endpoint memory, word count
`define TILE_MEM_WORDS 16

// tile id in the address top byte, y nibble over x nibble
`define TILE_ID_W 8

// full transaction address
`define TILE_ADDR_W 32

// read request tag carried in the payload
`define TILE_TAG_W 8

`endif

//--- tile_pkg.sv
// tile fabric types
`include "tile_consts.svh"

package tile_pkg;

    typedef logic [`TILE_ID_W-1:0] t_tile_id; // [7:4] y, [3:0] x

    // port directions, also the index into a ready vector
    typedef enum logic [2:0] {
        NORTH = 3'd0,
        EAST  = 3'd1,
        SOUTH = 3'd2,
        WEST  = 3'd3,
        LOCAL = 3'd4
    } t_cardinal;

    typedef enum logic [1:0] {
        WR     = 2'd0,
        RD     = 2'd1,
        RD_RSP = 2'd2
    } t_opcode;

    // read request view of the data word
    typedef struct packed {
        t_tile_id                return_id; // tile that gets the response
        logic [`TILE_TAG_W-1:0]  tag;       // echoed in the response address
        logic [15:0]             spare;
    } t_rd_req;

    typedef union packed {
        logic [31:0] raw;    // write data or read data
        t_rd_req     rd_req;
    } t_payload;

    typedef struct packed {
        logic [`TILE_ADDR_W-1:0] address;   // [31:24] destination tile
        t_opcode                 opcode;
        t_payload                payload;
        t_cardinal               next_tile_fifo_arb_id; // fifo to use at the receiving tile
    } t_tile_trans;

    typedef logic [4:0] t_fab_ready; // one bit per downstream fifo

endpackage

//--- tile_router.sv
// five port mesh router
`timescale 1ns/1ns

module tile_router
import tile_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  t_tile_id    local_tile_id,
    // ==========================================================
    // north
    input  logic        in_north_req_valid,
    input  t_tile_trans in_north_req,
    output t_fab_ready  out_north_ready,
    output logic        out_north_req_valid,
    output t_tile_trans out_north_req,
    input  t_fab_ready  in_north_ready,
    // ==========================================================
    // east
    input  logic        in_east_req_valid,
    input  t_tile_trans in_east_req,
    output t_fab_ready  out_east_ready,
    output logic        out_east_req_valid,
    output t_tile_trans out_east_req,
    input  t_fab_ready  in_east_ready,
    // ==========================================================
    // south
    input  logic        in_south_req_valid,
    input  t_tile_trans in_south_req,
    output t_fab_ready  out_south_ready,
    output logic        out_south_req_valid,
    output t_tile_trans out_south_req,
    input  t_fab_ready  in_south_ready,
    // ==========================================================
    // west
    input  logic        in_west_req_valid,
    input  t_tile_trans in_west_req,
    output t_fab_ready  out_west_ready,
    output logic        out_west_req_valid,
    output t_tile_trans out_west_req,
    input  t_fab_ready  in_west_ready,
    // ==========================================================
    // local
    input  logic        in_local_req_valid,
    input  t_tile_trans in_local_req,
    output t_fab_ready  out_local_ready,
    output logic        out_local_req_valid,
    output t_tile_trans out_local_req,
    input  t_fab_ready  in_local_ready
);

    logic        in_vld   [5];    // by input
    t_tile_trans in_trn   [5];
    t_fab_ready  in_nf    [5];    // [input] bit per output
    logic        arb_vld  [5];    // by output
    t_tile_trans arb_trn  [5];
    t_fab_ready  ds_rdy   [5];
    logic [4:0]  head_vld [5];    // [output] bit per input
    logic [4:0]  head_pop [5];
    t_tile_trans head_trn [5][5]; // [output][input]

    // side ports into arrays
    assign in_vld[NORTH] = in_north_req_valid;
    assign in_vld[EAST]  = in_east_req_valid;
    assign in_vld[SOUTH] = in_south_req_valid;
    assign in_vld[WEST]  = in_west_req_valid;
    assign in_vld[LOCAL] = in_local_req_valid;
    assign in_trn[NORTH] = in_north_req;
    assign in_trn[EAST]  = in_east_req;
    assign in_trn[SOUTH] = in_south_req;
    assign in_trn[WEST]  = in_west_req;
    assign in_trn[LOCAL] = in_local_req;
    assign ds_rdy[NORTH] = in_north_ready;
    assign ds_rdy[EAST]  = in_east_ready;
    assign ds_rdy[SOUTH] = in_south_ready;
    assign ds_rdy[WEST]  = in_west_ready;
    assign ds_rdy[LOCAL] = in_local_ready;

    assign out_north_ready = in_nf[NORTH];
    assign out_east_ready  = in_nf[EAST];
    assign out_south_ready = in_nf[SOUTH];
    assign out_west_ready  = in_nf[WEST];
    assign out_local_ready = in_nf[LOCAL];

    assign out_north_req_valid = arb_vld[NORTH];
    assign out_east_req_valid  = arb_vld[EAST];
    assign out_south_req_valid = arb_vld[SOUTH];
    assign out_west_req_valid  = arb_vld[WEST];
    assign out_local_req_valid = arb_vld[LOCAL];
    assign out_north_req = arb_trn[NORTH];
    assign out_east_req  = arb_trn[EAST];
    assign out_south_req = arb_trn[SOUTH];
    assign out_west_req  = arb_trn[WEST];
    assign out_local_req = arb_trn[LOCAL];

    // ==========================================================
    // input demux into fifos, picked by the arriving tag
    // ==========================================================
    for (genvar gi = 0; gi < 5; gi++) begin : g_in
        for (genvar go = 0; go < 5; go++) begin : g_out
            if (gi == go) begin : g_uturn
                assign in_nf[gi][go]    = 1'b0; // no way back out the same side
                assign head_vld[go][gi] = 1'b0;
                assign head_trn[go][gi] = '0;
            end else begin : g_fifo
                link_fifo u_fifo (
                    .clk       (clk),
                    .rst_n     (rst_n),
                    .wr_en     (in_vld[gi] && (in_trn[gi].next_tile_fifo_arb_id == 3'(go))),
                    .wr_data   (in_trn[gi]),
                    .rd_en     (head_pop[go][gi]),
                    .rd_data   (head_trn[go][gi]),
                    .not_empty (head_vld[go][gi]),
                    .not_full  (in_nf[gi][go])
                );
            end
        end
    end

    // ==========================================================
    // output arbiters
    // ==========================================================
    for (genvar go = 0; go < 5; go++) begin : g_arb
        out_port_arb #(
            .OUT_DIR (t_cardinal'(go))
        ) u_arb (
            .clk           (clk),
            .rst_n         (rst_n),
            .local_tile_id (local_tile_id),
            .src_valid     (head_vld[go]),
            .src_trans     (head_trn[go]),
            .src_pop       (head_pop[go]),
            .out_valid     (arb_vld[go]),
            .out_trans     (arb_trn[go]),
            .out_ready     (ds_rdy[go])
        );
    end

endmodule
